// File: common/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Core side word addressing
`define CS_WORD_ADDR_WIDTH 16
`define CS_WORD_WIDTH      32
`define CS_WORD_SIZE       4

// Line geometry
`define CS_WORDS_PER_LINE  4
`define CS_WORD_SEL_BITS   2
`define CS_LINE_WIDTH      128
`define CS_LINE_SIZE       16

// Direct mapped array shape
`define CS_NUM_LINES       64
`define CS_INDEX_BITS      6
`define CS_TAG_BITS        8
`define CS_LINE_ADDR_WIDTH 14

`define CS_CORE_TAG_WIDTH  4
`define CS_RSP_DEPTH       2

`endif

// File: common/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    // Word address split for the lookup
    typedef struct packed {
        logic [`CS_TAG_BITS-1:0]      tag;
        logic [`CS_INDEX_BITS-1:0]    index;
        logic [`CS_WORD_SEL_BITS-1:0] wsel;
    } cache_fields_t;

    // Same address seen from the memory port
    typedef struct packed {
        logic [`CS_LINE_ADDR_WIDTH-1:0] line;
        logic [`CS_WORD_SEL_BITS-1:0]   wsel;
    } cache_line_view_t;

    typedef union packed {
        cache_fields_t    f;
        cache_line_view_t l;
    } cache_addr_t;

    typedef struct packed {
        logic [`CS_WORD_ADDR_WIDTH-1:0] addr;
        logic                           rw;
        logic [`CS_WORD_SIZE-1:0]       byteen;
        logic [`CS_WORD_WIDTH-1:0]      data;
        logic [`CS_CORE_TAG_WIDTH-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [`CS_WORD_WIDTH-1:0]     data;
        logic [`CS_CORE_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_FILL_WAIT,
        LK_RESPOND
    } lookup_state_t;

endpackage

// File: common/cache_req_if.sv
`timescale 1ns/1ps

interface cache_req_if;
    import cache_pkg::*;

    logic        valid;
    logic        ready;
    core_req_t   req;
    // Address already viewed as cache fields
    cache_addr_t addr;

    modport source (
        output valid,
        output req,
        output addr,
        input  ready
    );

    modport sink (
        input  valid,
        input  req,
        input  addr,
        output ready
    );

endinterface

// File: common/cache_rsp_if.sv
`timescale 1ns/1ps
`include "cache_params.svh"

interface cache_rsp_if;

    logic                          valid;
    logic                          ready;
    logic [`CS_WORD_WIDTH-1:0]     data;
    logic [`CS_CORE_TAG_WIDTH-1:0] tag;

    modport source (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

// File: verilog/cache_req_decode.sv
`timescale 1ns/1ps

module cache_req_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  cache_pkg::core_req_t in_req,
    cache_req_if.source         req
);
    import cache_pkg::*;

    logic      valid_q;
    core_req_t req_q;

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready = !valid_q || req.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q <= in_req;
        end
    end

    assign req.valid = valid_q;
    assign req.req   = req_q;
    // Tag, index and word select come straight out of the union
    assign req.addr  = cache_addr_t'(req_q.addr);

    ////////////////////
    // Checks
    ////////////////////

    property p_req_hold;
        @(posedge clk) disable iff (reset)
        req.valid && !req.ready |=> req.valid && $stable(req.req);
    endproperty

    a_req_hold: assert property (p_req_hold)
        else $error("decode payload changed while stalled");

endmodule

// File: cache_lookup/cache_lookup.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_lookup (
    input  logic                           clk,
    input  logic                           reset,
    cache_req_if.sink                      req,
    cache_rsp_if.source                    rsp,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output logic [`CS_LINE_ADDR_WIDTH-1:0] mem_req_addr,
    output logic                           mem_req_rw,
    output logic [`CS_LINE_SIZE-1:0]       mem_req_byteen,
    output logic [`CS_LINE_WIDTH-1:0]      mem_req_data,
    input  logic                           mem_rsp_valid,
    output logic                           mem_rsp_ready,
    input  logic [`CS_LINE_WIDTH-1:0]      mem_rsp_data
);
    import cache_pkg::*;

    ////////////////////
    // Arrays
    ////////////////////

    logic [`CS_NUM_LINES-1:0]  valid_bits;
    logic [`CS_TAG_BITS-1:0]   tag_array  [`CS_NUM_LINES];
    logic [`CS_LINE_WIDTH-1:0] data_array [`CS_NUM_LINES];

    lookup_state_t                 state;
    cache_addr_t                   fill_addr;
    logic [`CS_CORE_TAG_WIDTH-1:0] rsp_tag_q;
    logic [`CS_WORD_WIDTH-1:0]     rsp_data_q;

    logic                      req_fire;
    logic                      mem_rsp_fire;
    logic                      hit;
    logic [`CS_LINE_WIDTH-1:0] cur_line;
    logic [`CS_LINE_WIDTH-1:0] wr_data_line;
    logic [`CS_LINE_SIZE-1:0]  wr_byteen_line;
    logic [`CS_LINE_WIDTH-1:0] merged_line;

    // Ready in idle with nothing pending toward memory
    assign req.ready     = (state == LK_IDLE) && !mem_req_valid;
    assign req_fire      = req.valid && req.ready;
    assign mem_rsp_ready = (state == LK_FILL_WAIT);
    assign mem_rsp_fire  = mem_rsp_valid && mem_rsp_ready;

    assign cur_line = data_array[req.addr.f.index];
    assign hit      = valid_bits[req.addr.f.index]
                      && (tag_array[req.addr.f.index] == req.addr.f.tag);

    // Place the write word in its lane, then merge for a hit
    always_comb begin
        wr_byteen_line = '0;
        wr_data_line   = '0;
        wr_byteen_line[req.addr.f.wsel * `CS_WORD_SIZE +: `CS_WORD_SIZE] = req.req.byteen;
        wr_data_line[req.addr.f.wsel * `CS_WORD_WIDTH +: `CS_WORD_WIDTH] = req.req.data;
        for (int i = 0; i < `CS_LINE_SIZE; i++) begin
            merged_line[i*8 +: 8] = wr_byteen_line[i] ? wr_data_line[i*8 +: 8]
                                                      : cur_line[i*8 +: 8];
        end
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= LK_IDLE;
            mem_req_valid <= 1'b0;
            valid_bits    <= '0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            case (state)
                LK_IDLE: begin
                    if (req_fire) begin
                        if (req.req.rw) begin
                            // Write through without a core response
                            mem_req_valid <= 1'b1;
                        end else if (hit) begin
                            state <= LK_RESPOND;
                        end else begin
                            mem_req_valid <= 1'b1;
                            state         <= LK_FILL_WAIT;
                        end
                    end
                end
                LK_FILL_WAIT: begin
                    if (mem_rsp_fire) begin
                        valid_bits[fill_addr.f.index] <= 1'b1;
                        state                         <= LK_RESPOND;
                    end
                end
                LK_RESPOND: begin
                    if (rsp.ready) begin
                        state <= LK_IDLE;
                    end
                end
                default: state <= LK_IDLE;
            endcase
        end
    end

    // Request payload and memory request fields
    always_ff @(posedge clk) begin
        if (req_fire) begin
            fill_addr      <= req.addr;
            rsp_tag_q      <= req.req.tag;
            rsp_data_q     <= cur_line[req.addr.f.wsel * `CS_WORD_WIDTH +: `CS_WORD_WIDTH];
            mem_req_addr   <= req.addr.l.line;
            mem_req_rw     <= req.req.rw;
            mem_req_byteen <= req.req.rw ? wr_byteen_line : '0;
            mem_req_data   <= req.req.rw ? wr_data_line : '0;
        end
        if (mem_rsp_fire) begin
            rsp_data_q <= mem_rsp_data[fill_addr.f.wsel * `CS_WORD_WIDTH +: `CS_WORD_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && req.req.rw && hit) begin
            data_array[req.addr.f.index] <= merged_line;
        end
        if (mem_rsp_fire) begin
            data_array[fill_addr.f.index] <= mem_rsp_data;
            tag_array[fill_addr.f.index]  <= fill_addr.f.tag;
        end
    end

    assign rsp.valid = (state == LK_RESPOND);
    assign rsp.data  = rsp_data_q;
    assign rsp.tag   = rsp_tag_q;

    ////////////////////
    // Checks
    ////////////////////

    property p_mem_req_hold;
        @(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid
            && $stable(mem_req_addr) && $stable(mem_req_rw)
            && $stable(mem_req_byteen) && $stable(mem_req_data);
    endproperty

    // Memory answers only after the fill read has gone out
    property p_mem_rsp_window;
        @(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (state == LK_FILL_WAIT) && !mem_req_valid;
    endproperty

    a_mem_req_hold: assert property (p_mem_req_hold)
        else $error("memory request changed while stalled");

    a_mem_rsp_window: assert property (p_mem_rsp_window)
        else $error("memory response outside fill wait");

endmodule

// File: verilog/cache_rsp_queue.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_rsp_queue (
    input  logic                 clk,
    input  logic                 reset,
    cache_rsp_if.sink            rsp,
    output logic                 out_valid,
    input  logic                 out_ready,
    output cache_pkg::core_rsp_t out_rsp
);
    import cache_pkg::*;

    localparam int PTR_BITS = $clog2(`CS_RSP_DEPTH);

    core_rsp_t           entries [`CS_RSP_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                push;
    logic                pop;

    assign rsp.ready = (count != `CS_RSP_DEPTH);
    assign out_valid = (count != 0);
    assign push      = rsp.valid && rsp.ready;
    assign pop       = out_valid && out_ready;
    // Head entry straight from storage
    assign out_rsp   = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= '{data: rsp.data, tag: rsp.tag};
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A response refused by a full queue is still offered next cycle
    property p_full_hold;
        @(posedge clk) disable iff (reset)
        rsp.valid && !rsp.ready |=> rsp.valid && $stable(rsp.data) && $stable(rsp.tag);
    endproperty

    a_full_hold: assert property (p_full_hold)
        else $error("response dropped while queue full");

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           core_req_valid,
    output logic                           core_req_ready,
    input  logic [`CS_WORD_ADDR_WIDTH-1:0] core_req_addr,
    input  logic                           core_req_rw,
    input  logic [`CS_WORD_SIZE-1:0]       core_req_byteen,
    input  logic [`CS_WORD_WIDTH-1:0]      core_req_data,
    input  logic [`CS_CORE_TAG_WIDTH-1:0]  core_req_tag,
    output logic                           core_rsp_valid,
    input  logic                           core_rsp_ready,
    output logic [`CS_WORD_WIDTH-1:0]      core_rsp_data,
    output logic [`CS_CORE_TAG_WIDTH-1:0]  core_rsp_tag,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output logic [`CS_LINE_ADDR_WIDTH-1:0] mem_req_addr,
    output logic                           mem_req_rw,
    output logic [`CS_LINE_SIZE-1:0]       mem_req_byteen,
    output logic [`CS_LINE_WIDTH-1:0]      mem_req_data,
    input  logic                           mem_rsp_valid,
    output logic                           mem_rsp_ready,
    input  logic [`CS_LINE_WIDTH-1:0]      mem_rsp_data
);
    import cache_pkg::*;

    core_req_t core_req;
    core_rsp_t core_rsp;

    cache_req_if req_if ();
    cache_rsp_if rsp_if ();

    // Core request ports packed into one record
    assign core_req = '{
        addr:   core_req_addr,
        rw:     core_req_rw,
        byteen: core_req_byteen,
        data:   core_req_data,
        tag:    core_req_tag
    };

    cache_req_decode i_decode (
        .clk      (clk),
        .reset    (reset),
        .in_valid (core_req_valid),
        .in_ready (core_req_ready),
        .in_req   (core_req),
        .req      (req_if.source)
    );

    cache_lookup i_lookup (
        .clk            (clk),
        .reset          (reset),
        .req            (req_if.sink),
        .rsp            (rsp_if.source),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_req_rw     (mem_req_rw),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .mem_rsp_data   (mem_rsp_data)
    );

    cache_rsp_queue i_rsp_queue (
        .clk       (clk),
        .reset     (reset),
        .rsp       (rsp_if.sink),
        .out_valid (core_rsp_valid),
        .out_ready (core_rsp_ready),
        .out_rsp   (core_rsp)
    );

    assign core_rsp_data = core_rsp.data;
    assign core_rsp_tag  = core_rsp.tag;

endmodule

// File: tb/tb_mem_model.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_mem_model (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mem_req_valid,
    output logic                           mem_req_ready,
    input  logic [`CS_LINE_ADDR_WIDTH-1:0] mem_req_addr,
    input  logic                           mem_req_rw,
    input  logic [`CS_LINE_SIZE-1:0]       mem_req_byteen,
    input  logic [`CS_LINE_WIDTH-1:0]      mem_req_data,
    output logic                           mem_rsp_valid,
    input  logic                           mem_rsp_ready,
    output logic [`CS_LINE_WIDTH-1:0]      mem_rsp_data
);

    logic [`CS_LINE_WIDTH-1:0]      shadow [2**`CS_LINE_ADDR_WIDTH];
    logic                           req_fire;
    logic                           rsp_fire;
    logic                           req_rw;
    logic [`CS_LINE_ADDR_WIDTH-1:0] req_line;
    logic [`CS_LINE_SIZE-1:0]       req_be;
    logic [`CS_LINE_WIDTH-1:0]      req_data;
    logic                           pending;
    logic [`CS_LINE_ADDR_WIDTH-1:0] pend_line;
    int                             delay;

    initial begin
        // Word value is its word address times 3 plus 0x1000
        for (int l = 0; l < 2**`CS_LINE_ADDR_WIDTH; l++) begin
            for (int w = 0; w < `CS_WORDS_PER_LINE; w++) begin
                shadow[l][w*`CS_WORD_WIDTH +: `CS_WORD_WIDTH] =
                    (l * `CS_WORDS_PER_LINE + w) * 3 + 32'h1000;
            end
        end
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        pending       = 1'b0;
        delay         = 0;
        forever begin
            // Handshakes sampled mid cycle complete at the next edge
            @(negedge clk);
            req_fire = !reset && mem_req_valid && mem_req_ready;
            rsp_fire = mem_rsp_valid && mem_rsp_ready;
            req_rw   = mem_req_rw;
            req_line = mem_req_addr;
            req_be   = mem_req_byteen;
            req_data = mem_req_data;
            @(posedge clk);
            if (req_fire && req_rw) begin
                for (int b = 0; b < `CS_LINE_SIZE; b++) begin
                    if (req_be[b]) begin
                        shadow[req_line][b*8 +: 8] = req_data[b*8 +: 8];
                    end
                end
            end else if (req_fire) begin
                pending   = 1'b1;
                pend_line = req_line;
                delay     = 1 + int'($urandom % 4);
            end
            #10;
            if (rsp_fire) begin
                mem_rsp_valid = 1'b0;
            end
            if (pending && delay == 1) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = shadow[pend_line];
                pending       = 1'b0;
            end else if (pending) begin
                delay--;
            end
            mem_req_ready = ($urandom % 4) != 0;
        end
    end

endmodule

// File: tb/tb_cache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_cache;
    import cache_pkg::*;

    localparam int NUM_REQS        = 400;
    localparam int SEED            = 4556;
    // Roughly 50 cycles per request covers fills and stalls
    localparam int WATCHDOG_CYCLES = NUM_REQS * 50;

    typedef struct packed {
        logic                           rw;
        logic [`CS_LINE_ADDR_WIDTH-1:0] line;
        logic [`CS_LINE_SIZE-1:0]       byteen;
        logic [`CS_WORD_SEL_BITS-1:0]   wsel;
        logic [`CS_WORD_WIDTH-1:0]      word;
    } mem_exp_t;

    logic                           clk;
    logic                           reset;
    logic                           core_req_valid;
    logic                           core_req_ready;
    logic [`CS_WORD_ADDR_WIDTH-1:0] core_req_addr;
    logic                           core_req_rw;
    logic [`CS_WORD_SIZE-1:0]       core_req_byteen;
    logic [`CS_WORD_WIDTH-1:0]      core_req_data;
    logic [`CS_CORE_TAG_WIDTH-1:0]  core_req_tag;
    logic                           core_rsp_valid;
    logic                           core_rsp_ready;
    logic [`CS_WORD_WIDTH-1:0]      core_rsp_data;
    logic [`CS_CORE_TAG_WIDTH-1:0]  core_rsp_tag;
    logic                           mem_req_valid;
    logic                           mem_req_ready;
    logic [`CS_LINE_ADDR_WIDTH-1:0] mem_req_addr;
    logic                           mem_req_rw;
    logic [`CS_LINE_SIZE-1:0]       mem_req_byteen;
    logic [`CS_LINE_WIDTH-1:0]      mem_req_data;
    logic                           mem_rsp_valid;
    logic                           mem_rsp_ready;
    logic [`CS_LINE_WIDTH-1:0]      mem_rsp_data;

    // Reference state
    logic [`CS_WORD_WIDTH-1:0]     ref_mem [2**`CS_WORD_ADDR_WIDTH];
    logic [`CS_NUM_LINES-1:0]      line_present = '0;
    logic [`CS_TAG_BITS-1:0]       line_tag [`CS_NUM_LINES];
    core_rsp_t                     rsp_q [$];
    mem_exp_t                      mem_q [$];
    core_rsp_t                     rsp_head;
    mem_exp_t                      mem_head;
    logic                          seen_accept = 1'b0;
    logic                          fill_open = 1'b0;
    logic [`CS_CORE_TAG_WIDTH-1:0] next_tag = '0;
    int rsp_count       = 0;
    int mem_count       = 0;
    int reads_accepted  = 0;
    int writes_accepted = 0;
    int rsps_seen       = 0;
    int errors          = 0;
    logic rsp_fire;
    logic mem_fire;

    cache_top i_dut (.*);
    tb_mem_model i_mem (.*);

    assign rsp_fire = core_rsp_valid && core_rsp_ready;
    assign mem_fire = mem_req_valid && mem_req_ready;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        for (int a = 0; a < 2**`CS_WORD_ADDR_WIDTH; a++) begin
            ref_mem[a] = a * 3 + 32'h1000;
        end
    end

    task automatic count_error(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////

    always @(posedge clk) begin
        logic [`CS_INDEX_BITS-1:0] idx;
        logic [`CS_TAG_BITS-1:0]   tag;
        mem_exp_t                  m;
        if (!reset) begin
            if (rsp_fire) begin
                rsps_seen++;
                if (rsp_q.size() != 0) void'(rsp_q.pop_front());
            end
            if (mem_fire && !mem_req_rw) begin
                fill_open = 1'b1;
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                fill_open = 1'b0;
            end
            if (mem_fire && mem_q.size() != 0) void'(mem_q.pop_front());
            if (core_req_valid && core_req_ready) begin
                seen_accept = 1'b1;
                idx      = core_req_addr[`CS_WORD_SEL_BITS +: `CS_INDEX_BITS];
                tag      = core_req_addr[`CS_WORD_ADDR_WIDTH-1 -: `CS_TAG_BITS];
                m.rw     = core_req_rw;
                m.line   = core_req_addr[`CS_WORD_ADDR_WIDTH-1:`CS_WORD_SEL_BITS];
                m.wsel   = core_req_addr[`CS_WORD_SEL_BITS-1:0];
                m.word   = core_req_data;
                m.byteen = '0;
                if (core_req_rw) begin
                    // Line byte b belongs to word b / 4
                    for (int b = 0; b < `CS_LINE_SIZE; b++) begin
                        m.byteen[b] = (b / `CS_WORD_SIZE == m.wsel)
                                      && core_req_byteen[b % `CS_WORD_SIZE];
                    end
                    for (int b = 0; b < `CS_WORD_SIZE; b++) begin
                        if (core_req_byteen[b]) begin
                            ref_mem[core_req_addr][b*8 +: 8] = core_req_data[b*8 +: 8];
                        end
                    end
                    mem_q.push_back(m);
                    writes_accepted++;
                end else begin
                    // Only reads allocate in the direct mapped model
                    if (!line_present[idx] || line_tag[idx] != tag) begin
                        mem_q.push_back(m);
                    end
                    line_present[idx] = 1'b1;
                    line_tag[idx]     = tag;
                    rsp_q.push_back('{data: ref_mem[core_req_addr], tag: core_req_tag});
                    reads_accepted++;
                end
            end
            rsp_count = rsp_q.size();
            mem_count = mem_q.size();
            if (rsp_count != 0) rsp_head = rsp_q[0];
            if (mem_count != 0) mem_head = mem_q[0];
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_quiet_start: assert property (@(posedge clk) disable iff (reset)
        !seen_accept |-> !core_rsp_valid && !mem_req_valid)
        else count_error("valid output before any request");
    a_rsp_known: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> rsp_count != 0)
        else count_error("response with no read outstanding");
    a_rsp_tag: assert property (@(posedge clk) disable iff (reset)
        rsp_fire && rsp_count != 0 |-> core_rsp_tag == rsp_head.tag)
        else count_error($sformatf("tag %0h, expected %0h", core_rsp_tag, rsp_head.tag));
    a_rsp_data: assert property (@(posedge clk) disable iff (reset)
        rsp_fire && rsp_count != 0 |-> core_rsp_data == rsp_head.data)
        else count_error($sformatf("read data %h, expected %h",
            core_rsp_data, rsp_head.data));
    a_mem_known: assert property (@(posedge clk) disable iff (reset)
        mem_fire |-> mem_count != 0)
        else count_error("memory request not expected");
    a_mem_kind: assert property (@(posedge clk) disable iff (reset)
        mem_fire && mem_count != 0 |-> mem_req_rw == mem_head.rw
            && mem_req_addr == mem_head.line)
        else count_error($sformatf("memory rw %0b line %h, expected %0b %h",
            mem_req_rw, mem_req_addr, mem_head.rw, mem_head.line));
    a_mem_byteen: assert property (@(posedge clk) disable iff (reset)
        mem_fire && mem_count != 0 && mem_head.rw |-> mem_req_byteen == mem_head.byteen)
        else count_error($sformatf("byte enable %h, expected %h",
            mem_req_byteen, mem_head.byteen));
    a_mem_lane: assert property (@(posedge clk) disable iff (reset)
        mem_fire && mem_count != 0 && mem_head.rw
            |-> mem_req_data[mem_head.wsel*`CS_WORD_WIDTH +: `CS_WORD_WIDTH] == mem_head.word)
        else count_error("write lane data wrong");
    // Memory response ready only while a fill read is out
    a_mem_rsp_ready: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_ready |-> fill_open || (mem_req_valid && !mem_req_rw))
        else count_error("memory response ready with no fill open");

    ////////////////////
    // Stimulus
    ////////////////////

    // Three tags over two indices, so lines evict each other
    function automatic logic [`CS_WORD_ADDR_WIDTH-1:0] pick_addr();
        logic [`CS_TAG_BITS-1:0]   tag;
        logic [`CS_INDEX_BITS-1:0] idx;
        case ($urandom % 3)
            0:       tag = 8'h12;
            1:       tag = 8'h34;
            default: tag = 8'h56;
        endcase
        idx = ($urandom % 2 == 0) ? 6'd3 : 6'd35;
        return {tag, idx, 2'($urandom)};
    endfunction

    task automatic send_req(input logic rw, input logic [`CS_WORD_ADDR_WIDTH-1:0] addr,
                            input logic [`CS_WORD_SIZE-1:0] be,
                            input logic [`CS_WORD_WIDTH-1:0] data);
        logic taken;
        core_req_valid  = 1'b1;
        core_req_rw     = rw;
        core_req_addr   = addr;
        core_req_byteen = be;
        core_req_data   = data;
        core_req_tag    = next_tag;
        taken           = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = core_req_ready;
            @(posedge clk);
            #10;
        end
        core_req_valid = 1'b0;
        next_tag       = next_tag + 4'd1;
    endtask

    initial begin
        core_rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            core_rsp_ready = reset ? 1'b0 : ($urandom % 3) != 0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the cache stopped responding",
            WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset           = 1'b1;
        core_req_valid  = 1'b0;
        core_req_addr   = '0;
        core_req_rw     = 1'b0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        for (int n = 0; n < NUM_REQS; n++) begin
            if ($urandom % 5 < 2) begin
                send_req(1'b1, pick_addr(), 4'($urandom), $urandom);
            end else begin
                send_req(1'b0, pick_addr(), 4'b0, 32'b0);
            end
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #10;
            end
        end
        while (rsp_count != 0 || mem_count != 0) begin
            @(posedge clk);
            #10;
        end
        repeat (4) @(posedge clk);
        #10;
        assert (rsps_seen == reads_accepted)
            else count_error($sformatf("%0d responses for %0d reads",
                rsps_seen, reads_accepted));
        $display("Reads %0d, writes %0d, responses %0d, errors %0d",
            reads_accepted, writes_accepted, rsps_seen, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/cache_pkg.sv
common/cache_req_if.sv
common/cache_rsp_if.sv
verilog/cache_req_decode.sv
cache_lookup/cache_lookup.sv
verilog/cache_rsp_queue.sv
verilog/cache_top.sv
tb/tb_mem_model.sv
tb/tb_cache.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat src.f))

.PHONY: run clean

obj_dir/Vtb_cache: src.f $(SRCS) common/cache_params.svh
	verilator --binary --timing --assert --top-module tb_cache -Mdir obj_dir -f src.f

run: obj_dir/Vtb_cache
	obj_dir/Vtb_cache | tee sim.log
	! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
